// ==== arithmeticLogicUnit.f ====
rtl/aluPkg.sv
rtl/aluDecoder.sv
rtl/aluAddSub.sv
rtl/aluLogic.sv
rtl/aluShifter.sv
rtl/aluFlagReg.sv
rtl/arithmeticLogicUnit.sv
verification/aluChecker.sv
verification/aluTb.sv

// ==== rtl/aluAddSub.sv ====
//**************************************************************************
// One adder for ADD, SUB and NEG, combinational
// Carry follows the no-borrow convention: SUB sets carry when RA >= RB
// Overflow is the two's complement sign rule on the adder operands
//**************************************************************************
`default_nettype none

module aluAddSub #(
	parameter int dataWidth = 32
) (
	input  aluPkg::arithOpE         arithOp,
	input  logic [dataWidth-1:0]    ra,
	input  logic [dataWidth-1:0]    rb,
	output logic [dataWidth-1:0]    arithResult,
	output logic                    arithCarry,
	output logic                    arithOverflow
);
	import aluPkg::*;

	logic [dataWidth-1:0] opA;	// Adder left operand
	logic [dataWidth-1:0] opB;	// Adder right operand, possibly inverted
	logic                 cin;
	logic [dataWidth:0]   sum;	// One extra bit for the carry out

	// Operand steering
	always_comb begin
		case (arithOp)
			arithSub: begin	// RA + ~RB + 1
				opA = ra;
				opB = ~rb;
				cin = 1'b1;
			end
			arithNeg: begin	// 0 + ~RA + 1
				opA = '0;
				opB = ~ra;
				cin = 1'b1;
			end
			default: begin	// Plain addition
				opA = ra;
				opB = rb;
				cin = 1'b0;
			end
		endcase
	end

	assign sum         = {1'b0, opA} + {1'b0, opB} + {{dataWidth{1'b0}}, cin};
	assign arithResult = sum[dataWidth-1:0];
	assign arithCarry  = sum[dataWidth];

	// Same-sign operands giving a different-sign result
	// For SUB this reads: RA and RB differ in sign, result differs from RA
	// For NEG it only fires when RA is the most negative value
	assign arithOverflow = (opA[dataWidth-1] == opB[dataWidth-1]) &&
		(arithResult[dataWidth-1] != opA[dataWidth-1]);

endmodule

`default_nettype wire

// ==== rtl/aluDecoder.sv ====
//**************************************************************************
// Purely combinational opcode decode
// Any opcode not listed in aluOpE raises opIllegal and selects no unit
//**************************************************************************
`default_nettype none

module aluDecoder (
	input  aluPkg::aluOpE    op,
	output aluPkg::aluUnitE  unitSel,
	output aluPkg::arithOpE  arithOp,
	output aluPkg::logicOpE  logicOp,
	output aluPkg::shiftOpE  shiftOp,
	output logic             updCarry,
	output logic             updOverflow,
	output logic             updZeroNeg,
	output logic             opIllegal,
	output logic             opIsNop
);
	import aluPkg::*;

	always_comb begin
		// Nothing selected and no flag may change by default
		unitSel     = unitNone;
		arithOp     = arithAdd;
		logicOp     = logicAnd;
		shiftOp     = shiftLsr;
		updCarry    = 1'b0;
		updOverflow = 1'b0;
		updZeroNeg  = 1'b0;
		opIllegal   = 1'b0;
		opIsNop     = 1'b0;

		case (op)
			opNop:  opIsNop = 1'b1;
			opAdd, opLbi: begin	// LBI is the same sum
				unitSel = unitArith;
				arithOp = arithAdd;
				{updCarry, updOverflow, updZeroNeg} = 3'b111;
			end
			opSub: begin
				unitSel = unitArith;
				arithOp = arithSub;
				{updCarry, updOverflow, updZeroNeg} = 3'b111;
			end
			opNeg: begin	// Carry holds on NEG
				unitSel = unitArith;
				arithOp = arithNeg;
				{updOverflow, updZeroNeg} = 2'b11;
			end
			opAnd:  {unitSel, logicOp, updZeroNeg} = {unitLogic, logicAnd, 1'b1};
			opOr:   {unitSel, logicOp, updZeroNeg} = {unitLogic, logicOr, 1'b1};
			opXor:  {unitSel, logicOp, updZeroNeg} = {unitLogic, logicXor, 1'b1};
			opComp: {unitSel, logicOp, updZeroNeg} = {unitLogic, logicComp, 1'b1};
			opMove: {unitSel, logicOp, updZeroNeg} = {unitLogic, logicPassA, 1'b1};
			opLdri, opLdi, opLdui:	// All three just pass RB
				{unitSel, logicOp, updZeroNeg} = {unitLogic, logicPassB, 1'b1};
			opLsr: {unitSel, shiftOp, updCarry, updZeroNeg} = {unitShift, shiftLsr, 2'b11};
			opAsr: {unitSel, shiftOp, updCarry, updZeroNeg} = {unitShift, shiftAsr, 2'b11};
			opLsl: {unitSel, shiftOp, updCarry, updZeroNeg} = {unitShift, shiftLsl, 2'b11};
			opRor: {unitSel, shiftOp, updCarry, updZeroNeg} = {unitShift, shiftRor, 2'b11};
			opRol: {unitSel, shiftOp, updCarry, updZeroNeg} = {unitShift, shiftRol, 2'b11};
			default: opIllegal = 1'b1;	// Unrecognized opcode
		endcase
	end

	// An X opcode would otherwise pass as an unrecognized instruction
	always_comb begin
		assert final (!$isunknown(op))
			else $error("Decoder sees an unknown opcode");
	end

endmodule

`default_nettype wire

// ==== rtl/aluFlagReg.sv ====
//**************************************************************************
// Result and condition-code registers load one cycle after the operation
// NOP holds everything
// An unrecognized opcode clears rz and holds carry, overflow, zero, negative
//**************************************************************************
`default_nettype none

module aluFlagReg #(
	parameter int dataWidth = 32
) (
	input  logic                    Clock,
	input  logic                    rstN,
	input  aluPkg::aluUnitE         unitSel,
	input  logic                    updCarry,
	input  logic                    updOverflow,
	input  logic                    updZeroNeg,
	input  logic                    opIllegal,
	input  logic                    opIsNop,
	input  logic [dataWidth-1:0]    arithResult,
	input  logic [dataWidth-1:0]    logicResult,
	input  logic [dataWidth-1:0]    shiftResult,
	input  logic                    arithCarry,
	input  logic                    arithOverflow,
	input  logic                    shiftCarry,
	output logic [dataWidth-1:0]    rz,
	output logic                    carry,	// Also the shifter's carryIn
	output logic                    overflow,
	output logic                    zero,
	output logic                    negative,
	output logic                    inrFlag,	// Instruction not recognized
	output logic                    ccrEnable
);
	import aluPkg::*;

	logic [dataWidth-1:0] nextResult;
	logic                 nextCarry;

	// With no unit selected the mux gives the 0 that an illegal opcode stores
	always_comb begin
		case (unitSel)
			unitArith: nextResult = arithResult;
			unitLogic: nextResult = logicResult;
			unitShift: nextResult = shiftResult;
			default:   nextResult = '0;
		endcase
	end

	// Only the adder and the shifter ever update carry
	assign nextCarry = (unitSel == unitShift) ? shiftCarry : arithCarry;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			rz        <= '0;
			carry     <= 1'b0;
			overflow  <= 1'b0;
			zero      <= 1'b0;
			negative  <= 1'b0;
			inrFlag   <= 1'b0;
			ccrEnable <= 1'b0;
		end else begin
			if (!opIsNop)
				rz <= nextResult;	// Held across NOP
			if (updCarry)
				carry <= nextCarry;
			if (updOverflow)
				overflow <= arithOverflow;
			if (updZeroNeg) begin	// Taken from the new rz
				zero     <= (nextResult == '0);
				negative <= nextResult[dataWidth-1];
			end
			inrFlag   <= opIllegal;
			ccrEnable <= !opIsNop && !opIllegal;
		end
	end

	// Zero and negative are only updated from a real unit
	assert property (@(posedge Clock) disable iff (!rstN)
		updZeroNeg |-> !$isunknown(unitSel) && unitSel != unitNone)
		else $error("Zero/negative update with no unit selected");

	// An unrecognized instruction changes no condition flag
	assert property (@(posedge Clock) disable iff (!rstN)
		opIllegal |-> !updCarry && !updOverflow && !updZeroNeg && unitSel == unitNone)
		else $error("Unrecognized opcode would update a condition flag");

endmodule

`default_nettype wire

// ==== rtl/aluLogic.sv ====
//**************************************************************************
// Bitwise operations and operand pass-through, combinational
// COMP and MOVE use RA only; the loads take RB as already prepared
//**************************************************************************
`default_nettype none

module aluLogic #(
	parameter int dataWidth = 32
) (
	input  aluPkg::logicOpE         logicOp,
	input  logic [dataWidth-1:0]    ra,
	input  logic [dataWidth-1:0]    rb,
	output logic [dataWidth-1:0]    logicResult
);
	import aluPkg::*;

	always_comb begin
		case (logicOp)
			logicAnd:   logicResult = ra & rb;
			logicOr:    logicResult = ra | rb;
			logicXor:   logicResult = ra ^ rb;
			logicComp:  logicResult = ~ra;	// One's complement
			logicPassA: logicResult = ra;	// MOVE
			logicPassB: logicResult = rb;	// LDRI, LDI, LDUI
			default:    logicResult = '0;	// Unused encodings
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/aluPkg.sv ====
//**************************************************************************
// Shared opcodes and internal select encodings for the ALU
// Opcode values follow the instruction encoding; 16..31 and 34..63 are unused
// Widths here are defaults only; the top level passes dataWidth down
//**************************************************************************
`default_nettype none

package aluPkg;

	// Default operand width
	parameter int defaultDataWidth = 32;
	// Opcode field width
	parameter int opWidth = 6;

	// Opcodes as decoded by the ALU
	typedef enum logic [opWidth-1:0] {
		opNop  = 6'd0,	// No operation, everything holds
		opAdd  = 6'd1,
		opSub  = 6'd2,
		opAnd  = 6'd3,
		opOr   = 6'd4,
		opNeg  = 6'd5,	// Two's complement of RA
		opXor  = 6'd6,
		opComp = 6'd7,	// One's complement of RA
		opLsr  = 6'd8,
		opAsr  = 6'd9,
		opLsl  = 6'd10,
		opRor  = 6'd11,	// Rotate right through carry
		opRol  = 6'd12,	// Rotate left through carry
		opMove = 6'd13,	// RA passes through
		opLdri = 6'd14,	// RB passes through
		opLbi  = 6'd15,	// Same addition as ADD
		opLdi  = 6'd32,	// Immediate already on RB
		opLdui = 6'd33
	} aluOpE;

	// Which unit supplies the next result
	typedef enum logic [1:0] {
		unitNone,	// NOP or unrecognized opcode
		unitArith,
		unitLogic,
		unitShift
	} aluUnitE;

	// Adder operations
	typedef enum logic [1:0] {
		arithAdd,
		arithSub,
		arithNeg	// Zero minus RA
	} arithOpE;

	// Logic unit operations
	typedef enum logic [2:0] {
		logicAnd,
		logicOr,
		logicXor,
		logicComp,
		logicPassA,
		logicPassB
	} logicOpE;

	// Single-position shifts
	typedef enum logic [2:0] {
		shiftLsr,
		shiftAsr,
		shiftLsl,
		shiftRor,
		shiftRol
	} shiftOpE;

endpackage

`default_nettype wire

// ==== rtl/aluShifter.sv ====
//**************************************************************************
// One-position shifts and rotates, combinational
// Rotates go through the carry flag, so the result depends on the carry
// left by the previous operation (carryIn comes from the flag register)
//**************************************************************************
`default_nettype none

module aluShifter #(
	parameter int dataWidth = 32
) (
	input  aluPkg::shiftOpE         shiftOp,
	input  logic [dataWidth-1:0]    ra,
	input  logic                    carryIn,	// Registered carry
	output logic [dataWidth-1:0]    shiftResult,
	output logic                    shiftCarry	// Bit shifted out
);
	import aluPkg::*;

	logic msb;	// Sign bit of RA
	logic lsb;

	assign msb = ra[dataWidth-1];
	assign lsb = ra[0];

	always_comb begin
		case (shiftOp)
			shiftLsr: begin	// Zero fill from the top
				shiftResult = {1'b0, ra[dataWidth-1:1]};
				shiftCarry  = lsb;
			end
			shiftAsr: begin	// Sign extends
				shiftResult = {msb, ra[dataWidth-1:1]};
				shiftCarry  = lsb;
			end
			shiftLsl: begin	// Also serves as ASL
				shiftResult = {ra[dataWidth-2:0], 1'b0};
				shiftCarry  = msb;
			end
			shiftRor: begin
				shiftResult = {carryIn, ra[dataWidth-1:1]};	// Old carry into the top
				shiftCarry  = lsb;
			end
			shiftRol: begin
				shiftResult = {ra[dataWidth-2:0], carryIn};	// Old carry into bit 0
				shiftCarry  = msb;
			end
			default: begin	// Unused encodings leave RA and carry as they are
				shiftResult = ra;
				shiftCarry  = carryIn;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/arithmeticLogicUnit.sv ====
//**************************************************************************
// Registered ALU top: results and flags appear one cycle after op/ra/rb
// One operation per cycle, no handshake and no back-pressure
// Synchronous active-low reset clears rz and all flags
//**************************************************************************
`default_nettype none

module arithmeticLogicUnit #(
	parameter int dataWidth = aluPkg::defaultDataWidth
) (
	input  logic                    Clock,
	input  logic                    rstN,
	input  aluPkg::aluOpE           op,
	input  logic [dataWidth-1:0]    ra,
	input  logic [dataWidth-1:0]    rb,
	output logic [dataWidth-1:0]    rz,
	output logic                    carry,
	output logic                    overflow,
	output logic                    zero,
	output logic                    negative,
	output logic                    inrFlag,
	output logic                    ccrEnable
);
	import aluPkg::*;

	// Decoder outputs
	aluUnitE unitSel;
	arithOpE arithOp;
	logicOpE logicOp;
	shiftOpE shiftOp;
	logic    updCarry;
	logic    updOverflow;
	logic    updZeroNeg;
	logic    opIllegal;
	logic    opIsNop;

	// Unit results
	logic [dataWidth-1:0] arithResult;
	logic [dataWidth-1:0] logicResult;
	logic [dataWidth-1:0] shiftResult;
	logic                 arithCarry;
	logic                 arithOverflow;
	logic                 shiftCarry;

	aluDecoder aluDecoder_i (
		.op(op), .unitSel(unitSel), .arithOp(arithOp), .logicOp(logicOp),
		.shiftOp(shiftOp), .updCarry(updCarry), .updOverflow(updOverflow),
		.updZeroNeg(updZeroNeg), .opIllegal(opIllegal), .opIsNop(opIsNop)
	);

	aluAddSub #(.dataWidth(dataWidth)) aluAddSub_i (
		.arithOp(arithOp), .ra(ra), .rb(rb), .arithResult(arithResult),
		.arithCarry(arithCarry), .arithOverflow(arithOverflow)
	);

	aluLogic #(.dataWidth(dataWidth)) aluLogic_i (
		.logicOp(logicOp), .ra(ra), .rb(rb), .logicResult(logicResult)
	);

	// Rotates read the carry registered by the previous operation
	aluShifter #(.dataWidth(dataWidth)) aluShifter_i (
		.shiftOp(shiftOp), .ra(ra), .carryIn(carry),
		.shiftResult(shiftResult), .shiftCarry(shiftCarry)
	);

	aluFlagReg #(.dataWidth(dataWidth)) aluFlagReg_i (
		.Clock(Clock), .rstN(rstN), .unitSel(unitSel), .updCarry(updCarry),
		.updOverflow(updOverflow), .updZeroNeg(updZeroNeg),
		.opIllegal(opIllegal), .opIsNop(opIsNop),
		.arithResult(arithResult), .logicResult(logicResult),
		.shiftResult(shiftResult), .arithCarry(arithCarry),
		.arithOverflow(arithOverflow), .shiftCarry(shiftCarry),
		.rz(rz), .carry(carry), .overflow(overflow), .zero(zero),
		.negative(negative), .inrFlag(inrFlag), .ccrEnable(ccrEnable)
	);

endmodule

`default_nettype wire

// ==== verification/aluChecker.sv ====
//**************************************************************************
// Compares DUT outputs with the table row applied one cycle earlier
// Expected values arrive with the stimulus and are delayed here by a cycle
// Outputs are sampled on the falling edge, away from the register update
//**************************************************************************
`default_nettype none

module aluChecker #(
	parameter int dataWidth = 32
) (
	input  logic                    Clock,
	input  logic                    stimValid,
	input  int                      stimIdx,
	input  logic [dataWidth-1:0]    expRz,
	input  logic                    expCarry,
	input  logic                    expOverflow,
	input  logic                    expZero,
	input  logic                    expNegative,
	input  logic                    expInr,
	input  logic                    expCcr,
	input  logic [dataWidth-1:0]    rz,
	input  logic                    carry,
	input  logic                    overflow,
	input  logic                    zero,
	input  logic                    negative,
	input  logic                    inrFlag,
	input  logic                    ccrEnable,
	output int                      errorCount,
	output int                      rowsChecked,
	output int                      rowsFailed
);

	logic                 chkValid;	// Row whose result is now on the outputs
	int                   chkIdx;
	logic [dataWidth-1:0] expRzQ;
	logic [5:0]           expFlagsQ;	// {c, v, z, n, inr, ccrEnable}
	int                   rowErrors;

	initial begin
		chkValid = 1'b0;
		errorCount = 0;
		rowsChecked = 0;
		rowsFailed = 0;
	end

	task automatic compareWord(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED row %0d: %s got 0x%h expected 0x%h",
				chkIdx, name, got, expected);
			rowErrors++;
			errorCount++;
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("CHECK FAILED row %0d: %s got 0x%h expected 0x%h",
				chkIdx, name, got, expected);
			rowErrors++;
			errorCount++;
		end
	endtask

	// One-cycle delay matches the DUT latency
	always @(posedge Clock) begin
		chkValid  <= stimValid;
		chkIdx    <= stimIdx;
		expRzQ    <= expRz;
		expFlagsQ <= {expCarry, expOverflow, expZero, expNegative, expInr, expCcr};
	end

	always @(negedge Clock) begin
		if (chkValid) begin
			rowErrors = 0;
			compareWord("rz", rz, expRzQ);
			compareFlag("carry", carry, expFlagsQ[5]);
			compareFlag("overflow", overflow, expFlagsQ[4]);
			compareFlag("zero", zero, expFlagsQ[3]);
			compareFlag("negative", negative, expFlagsQ[2]);
			compareFlag("inrFlag", inrFlag, expFlagsQ[1]);
			compareFlag("ccrEnable", ccrEnable, expFlagsQ[0]);
			rowsChecked++;
			if (rowErrors == 0) begin
				$display("Row %0d ok, rz 0x%h", chkIdx, rz);
			end else begin
				rowsFailed++;
				$display("Row %0d had %0d mismatches", chkIdx, rowErrors);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/aluTb.sv ====
//**************************************************************************
// Testbench for the registered ALU, 32-bit operands
// Expected values in the table assume the rows run in order from reset,
// since carry, overflow, zero and negative carry over between rows
//**************************************************************************
`default_nettype none

module aluTb;
	import aluPkg::*;

	localparam int dataWidth   = 32;
	localparam int numRows     = 30;
	localparam int resetCycles = 4;
	localparam int clkPeriod   = 8;
	localparam int timeoutCycles = numRows + resetCycles + 10;

	// DUT inputs
	logic                 Clock;
	logic                 rstN;
	aluOpE                op;
	logic [dataWidth-1:0] ra;
	logic [dataWidth-1:0] rb;

	// DUT outputs
	logic [dataWidth-1:0] rz;
	logic                 carry, overflow, zero, negative, inrFlag, ccrEnable;

	// Stimulus table, flags packed as {c, v, z, n, inr, ccrEnable}
	logic [5:0]           opTab[numRows];
	logic [dataWidth-1:0] raTab[numRows];
	logic [dataWidth-1:0] rbTab[numRows];
	logic [dataWidth-1:0] rzTab[numRows];
	logic [5:0]           flagTab[numRows];
	int                   rowCount;
	integer               seed;	// Operands of rows whose result ignores them

	// Expected values travelling with each row to the checker
	logic                 stimValid;
	int                   stimIdx;
	logic [dataWidth-1:0] expRz;
	logic                 expCarry, expOverflow, expZero, expNegative, expInr, expCcr;
	int                   errorCount, rowsChecked, rowsFailed;

	always #(clkPeriod / 2) Clock = ~Clock;

	arithmeticLogicUnit #(.dataWidth(dataWidth)) arithmeticLogicUnit_i (
		.Clock(Clock), .rstN(rstN), .op(op), .ra(ra), .rb(rb), .rz(rz),
		.carry(carry), .overflow(overflow), .zero(zero), .negative(negative),
		.inrFlag(inrFlag), .ccrEnable(ccrEnable)
	);

	aluChecker #(.dataWidth(dataWidth)) aluChecker_i (
		.Clock(Clock), .stimValid(stimValid), .stimIdx(stimIdx), .expRz(expRz),
		.expCarry(expCarry), .expOverflow(expOverflow), .expZero(expZero),
		.expNegative(expNegative), .expInr(expInr), .expCcr(expCcr),
		.rz(rz), .carry(carry), .overflow(overflow), .zero(zero),
		.negative(negative), .inrFlag(inrFlag), .ccrEnable(ccrEnable),
		.errorCount(errorCount), .rowsChecked(rowsChecked), .rowsFailed(rowsFailed)
	);

	task automatic addRow(input logic [5:0] rowOp, input logic [31:0] rowRa,
		input logic [31:0] rowRb, input logic [31:0] rowRz, input logic [5:0] rowFlags);
		opTab[rowCount]   = rowOp;
		raTab[rowCount]   = rowRa;
		rbTab[rowCount]   = rowRb;
		rzTab[rowCount]   = rowRz;
		flagTab[rowCount] = rowFlags;
		rowCount++;
	endtask

	// Ends a run that stops making progress
	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Run timed out after %0d cycles without finishing the table", timeoutCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		Clock = 1'b0;
		rstN = 1'b0;
		op = opNop;
		ra = '0;
		rb = '0;
		stimValid = 1'b0;
		stimIdx = 0;
		expRz = '0;
		{expCarry, expOverflow, expZero, expNegative, expInr, expCcr} = 6'b0;
		rowCount = 0;
		seed = 32'haaff;
		//     op      ra            rb            rz            cvznie
		addRow(opNop,  $random(seed), $random(seed), 32'h0,        6'b000000);	// Reset state held
		addRow(opAdd,  32'h7fffffff, 32'h00000001, 32'h80000000, 6'b010101);	// Signed overflow
		addRow(opNop,  $random(seed), $random(seed), 32'h80000000, 6'b010100);
		addRow(opAdd,  32'hffffffff, 32'h00000001, 32'h00000000, 6'b101001);	// Carry out, zero
		addRow(opLbi,  32'h00000010, 32'h00000020, 32'h00000030, 6'b000001);
		addRow(opSub,  32'h00000000, 32'h00000001, 32'hffffffff, 6'b000101);	// Borrow clears carry
		addRow(opSub,  32'h00000005, 32'h00000003, 32'h00000002, 6'b100001);
		addRow(opSub,  32'h80000000, 32'h00000001, 32'h7fffffff, 6'b110001);	// Overflow on SUB
		addRow(opNeg,  32'h00000001, 32'h0,        32'hffffffff, 6'b100101);	// Carry held
		addRow(opNeg,  32'h80000000, 32'h0,        32'h80000000, 6'b110101);	// Most negative
		addRow(opAnd,  32'hf0f0f0f0, 32'h0ff00ff0, 32'h00f000f0, 6'b110001);
		addRow(opOr,   32'h0000ffff, 32'hffff0000, 32'hffffffff, 6'b110101);
		addRow(opXor,  32'ha5a5a5a5, 32'ha5a5a5a5, 32'h00000000, 6'b111001);
		addRow(opComp, 32'h0000ffff, 32'h12345678, 32'hffff0000, 6'b110101);
		addRow(opMove, 32'h12345678, 32'h00000009, 32'h12345678, 6'b110001);
		addRow(opLdri, 32'h00000001, 32'h87654321, 32'h87654321, 6'b110101);
		addRow(opLdi,  32'hffffffff, 32'h00000000, 32'h00000000, 6'b111001);
		addRow(opLdui, 32'h00000000, 32'habcd0000, 32'habcd0000, 6'b110101);
		addRow(opLsr,  32'h80000001, 32'h0,        32'h40000000, 6'b110001);
		addRow(opAsr,  32'h80000002, 32'h0,        32'hc0000001, 6'b010101);	// Sign extends
		addRow(opLsl,  32'h40000001, 32'h0,        32'h80000002, 6'b010101);
		addRow(opLsl,  32'h80000000, 32'h0,        32'h00000000, 6'b111001);	// Sets carry
		addRow(opRor,  32'h00000002, 32'h0,        32'h80000001, 6'b010101);	// Carry 1 into top
		addRow(opRor,  32'h00000004, 32'h0,        32'h00000002, 6'b010001);
		addRow(opRol,  32'h80000000, 32'h0,        32'h00000000, 6'b111001);	// Carry 0 into bit 0
		addRow(opRol,  32'h00000001, 32'h0,        32'h00000003, 6'b010001);
		addRow(6'd20,  $random(seed), $random(seed), 32'h0,        6'b010010);	// Unrecognized
		addRow(opAdd,  32'h00000001, 32'h00000002, 32'h00000003, 6'b000001);	// Clears inrFlag
		addRow(6'd63,  $random(seed), $random(seed), 32'h0,        6'b000010);
		addRow(opNop,  $random(seed), $random(seed), 32'h0,        6'b000000);

		repeat (resetCycles) @(posedge Clock);
		rstN <= 1'b1;
		for (int i = 0; i < numRows; i++) begin
			op <= aluOpE'(opTab[i]);
			ra <= raTab[i];
			rb <= rbTab[i];
			stimValid <= 1'b1;
			stimIdx <= i;
			expRz <= rzTab[i];
			{expCarry, expOverflow, expZero, expNegative, expInr, expCcr} <= flagTab[i];
			@(posedge Clock);
		end
		stimValid <= 1'b0;
		op <= opNop;
		repeat (3) @(posedge Clock);	// Last row reaches the checker

		$display("Rows checked %0d of %0d, rows failed %0d, mismatches %0d",
			rowsChecked, numRows, rowsFailed, errorCount);
		if (errorCount == 0 && rowsChecked == numRows) begin
			$display("SIMULATION PASSED");
		end else begin
			if (rowsChecked != numRows)
				$display("Not every table row was checked");
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
